/* design/ahb_switch.sv */
module ahb_switch import ahb_switch_pkg::*; (
   input  logic    HCLOCK,
   input  logic    HRESETn,

   // AHB masters
   input  addr_t   haddr         [num_masters],
   input  htrans_t htrans        [num_masters],
   input  logic    hwrite        [num_masters],
   input  hsize_t  hsize         [num_masters],
   input  data_t   hwdata        [num_masters],
   output logic    hready        [num_masters],
   output data_t   hrdata        [num_masters],
   output hresp_t  hresp         [num_masters],

   // chip-select slaves
   output addr_t   s_address     [num_slaves],
   output logic    s_chip_select [num_slaves],
   output strobe_t s_byte_enable [num_slaves],
   output logic    s_write       [num_slaves],
   output htrans_t s_trans       [num_slaves],
   output data_t   s_wdata       [num_slaves],
   input  data_t   s_rdata       [num_slaves],
   input  hresp_t  s_resp        [num_slaves],
   input  logic    s_ready       [num_slaves]
);

   master_link_if mlink [num_masters] ();
   slave_link_if  slink [num_slaves] ();

   genvar m;
   genvar s;

   generate
      // input side, one per master
      for (m = 0; m < num_masters; m++) begin : g_master
         master_port master_port_inst (
            .HCLOCK  (HCLOCK),
            .HRESETn (HRESETn),
            .haddr   (haddr[m]),
            .htrans  (htrans[m]),
            .hwrite  (hwrite[m]),
            .hsize   (hsize[m]),
            .hwdata  (hwdata[m]),
            .hready  (hready[m]),
            .hrdata  (hrdata[m]),
            .hresp   (hresp[m]),
            .link    (mlink[m])
         );
      end
   endgenerate

   switch_router switch_router_inst (
      .HCLOCK  (HCLOCK),
      .HRESETn (HRESETn),
      .mlink   (mlink),
      .slink   (slink)
   );

   generate
      // output side, one per slave
      for (s = 0; s < num_slaves; s++) begin : g_slave
         slave_port slave_port_inst (
            .HCLOCK        (HCLOCK),
            .HRESETn       (HRESETn),
            .link          (slink[s]),
            .s_address     (s_address[s]),
            .s_chip_select (s_chip_select[s]),
            .s_byte_enable (s_byte_enable[s]),
            .s_write       (s_write[s]),
            .s_trans       (s_trans[s]),
            .s_wdata       (s_wdata[s]),
            .s_rdata       (s_rdata[s]),
            .s_resp        (s_resp[s]),
            .s_ready       (s_ready[s])
         );
      end
   endgenerate

endmodule

/* design/ahb_switch_pkg.sv */
package ahb_switch_pkg;

   // switch dimensions
   localparam int num_masters  = 2;
   localparam int num_slaves   = 2;
   localparam int addr_width   = 32;
   localparam int data_width   = 32;
   localparam int strobe_width = 4;

   typedef logic [addr_width-1:0]   addr_t;
   typedef logic [data_width-1:0]   data_t;
   typedef logic [strobe_width-1:0] strobe_t;

   // AHB transfer type, BUSY is handled like IDLE by the switch
   typedef enum logic [1:0] {
      trans_idle   = 2'b00,
      trans_busy   = 2'b01,
      trans_nonseq = 2'b10,
      trans_seq    = 2'b11
   } htrans_t;

   typedef logic [2:0] hsize_t;

   localparam hsize_t size_byte = 3'b000;
   localparam hsize_t size_half = 3'b001;
   localparam hsize_t size_word = 3'b010;

   typedef enum logic [1:0] {
      resp_okay  = 2'b00,
      resp_error = 2'b01
   } hresp_t;

   typedef logic [$clog2(num_slaves)-1:0]  slave_idx_t;
   typedef logic [$clog2(num_masters)-1:0] master_idx_t;

   // top address nibble of each slave region
   localparam logic [3:0] slave_base_0 = 4'h0;
   localparam logic [3:0] slave_base_1 = 4'h4;

   // returns the hit flag, idx is only meaningful on a hit
   function automatic logic decode_slave(input addr_t addr, output slave_idx_t idx);
      logic [3:0] nibble;
      logic       hit;
      nibble = addr[addr_width-1 -: 4];
      hit    = 1'b1;
      idx    = '0;
      case (nibble)
         slave_base_0: idx = slave_idx_t'(0);
         slave_base_1: idx = slave_idx_t'(1);
         default:      hit = 1'b0;
      endcase
      return hit;
   endfunction

   // lane k belongs to byte offset k of the word
   function automatic strobe_t byte_lanes(input hsize_t size, input logic [1:0] low);
      strobe_t lanes;
      case (size)
         size_byte: lanes = strobe_t'(1) << low;
         size_half: lanes = low[1] ? strobe_t'(4'b1100) : strobe_t'(4'b0011);
         size_word: lanes = '1;
         // wider than the bus, no lanes
         default:   lanes = '0;
      endcase
      return lanes;
   endfunction

endpackage

/* design/master_link_if.sv */
interface master_link_if import ahb_switch_pkg::*; ();

   // request side, held from acceptance until done
   logic       req;
   addr_t      addr;
   htrans_t    trans;
   logic       write;
   strobe_t    strobe;
   slave_idx_t target;
   // live write data of the master's data phase
   data_t      wdata;

   // completion side, from the owned slave only
   logic       done;
   data_t      rdata;
   hresp_t     resp;

   modport master (
      output req, addr, trans, write, strobe, target, wdata,
      input  done, rdata, resp
   );

   modport router (
      input  req, addr, trans, write, strobe, target, wdata,
      output done, rdata, resp
   );

endinterface

/* design/master_port.sv */
module master_port import ahb_switch_pkg::*; (
   input  logic          HCLOCK,
   input  logic          HRESETn,
   input  addr_t         haddr,
   input  htrans_t       htrans,
   input  logic          hwrite,
   input  hsize_t        hsize,
   input  data_t         hwdata,
   output logic          hready,
   output data_t         hrdata,
   output hresp_t        hresp,
   master_link_if.master link
);

   logic       accept;
   logic       map_hit;
   slave_idx_t map_idx;

   // control state
   logic       req_q;
   logic       err_first;
   logic       err_last;

   // held address phase
   addr_t      addr_q;
   htrans_t    trans_q;
   logic       write_q;
   strobe_t    strobe_q;
   slave_idx_t target_q;

   // only NONSEQ and SEQ start a transfer, BUSY counts as idle
   assign accept = hready && (htrans == trans_nonseq || htrans == trans_seq);

   always_comb begin
      map_hit = decode_slave(haddr, map_idx);
   end

   always_ff @(posedge HCLOCK or negedge HRESETn) begin
      if (!HRESETn) begin
         req_q     <= 1'b0;
         err_first <= 1'b0;
         err_last  <= 1'b0;
      end else begin
         // second error cycle always follows the first
         err_last <= err_first;
         if (accept) begin
            // a new transfer may come in the same cycle as done
            req_q     <= map_hit;
            err_first <= !map_hit;
         end else begin
            if (link.done) begin
               req_q <= 1'b0;
            end
            err_first <= 1'b0;
         end
      end
   end

   always_ff @(posedge HCLOCK) begin
      if (accept) begin
         addr_q   <= haddr;
         trans_q  <= htrans;
         write_q  <= hwrite;
         strobe_q <= byte_lanes(hsize, haddr[1:0]);
         target_q <= map_idx;
      end
   end

   // stall until the slave finishes, or for the first error cycle
   assign hready = req_q ? link.done : !err_first;

   // two cycle ERROR for unmapped addresses, else the slave response
   assign hresp  = (err_first || err_last) ? resp_error :
                   (req_q ? link.resp : resp_okay);

   // router returns zero unless this master owns a slave
   assign hrdata = link.rdata;

   assign link.req    = req_q;
   assign link.addr   = addr_q;
   assign link.trans  = trans_q;
   assign link.write  = write_q;
   assign link.strobe = strobe_q;
   assign link.target = target_q;
   // master holds HWDATA while stalled
   assign link.wdata  = hwdata;

endmodule

/* design/slave_link_if.sv */
interface slave_link_if import ahb_switch_pkg::*; ();

   // one cycle pulse opens the slave address phase
   logic    start;
   addr_t   addr;
   htrans_t trans;
   logic    write;
   strobe_t strobe;
   data_t   wdata;

   // done mirrors S_READY while in the data phase
   logic    done;
   data_t   rdata;
   hresp_t  resp;

   modport router (
      output start, addr, trans, write, strobe, wdata,
      input  done, rdata, resp
   );

   modport slave (
      input  start, addr, trans, write, strobe, wdata,
      output done, rdata, resp
   );

endinterface

/* design/slave_port.sv */
module slave_port import ahb_switch_pkg::*; (
   input  logic         HCLOCK,
   input  logic         HRESETn,
   slave_link_if.slave  link,
   output addr_t        s_address,
   output logic         s_chip_select,
   output strobe_t      s_byte_enable,
   output logic         s_write,
   output htrans_t      s_trans,
   output data_t        s_wdata,
   input  data_t        s_rdata,
   input  hresp_t       s_resp,
   input  logic         s_ready
);

   logic data_phase;

   // data phase runs from the cycle after start until S_READY
   always_ff @(posedge HCLOCK or negedge HRESETn) begin
      if (!HRESETn) begin
         data_phase <= 1'b0;
      end else begin
         if (link.start) begin
            data_phase <= 1'b1;
         end else if (data_phase && s_ready) begin
            data_phase <= 1'b0;
         end
      end
   end

   // address phase fields only during the start cycle
   assign s_chip_select = link.start;
   assign s_address     = link.start ? link.addr : '0;
   assign s_byte_enable = link.start ? link.strobe : '0;
   assign s_write       = link.start && link.write;
   assign s_trans       = link.start ? link.trans : trans_idle;

   // write data is live for the whole data phase
   assign s_wdata       = data_phase ? link.wdata : '0;

   // wait states stretch the data phase
   assign link.done     = data_phase && s_ready;
   assign link.rdata    = data_phase ? s_rdata : '0;
   assign link.resp     = data_phase ? s_resp : resp_okay;

endmodule

/* design/switch_router.sv */
module switch_router import ahb_switch_pkg::*; (
   input  logic          HCLOCK,
   input  logic          HRESETn,
   master_link_if.router mlink [num_masters],
   slave_link_if.router  slink [num_slaves]
);

   // flat copies of the links so they can be indexed at run time
   logic        m_req    [num_masters];
   addr_t       m_addr   [num_masters];
   htrans_t     m_trans  [num_masters];
   logic        m_write  [num_masters];
   strobe_t     m_strobe [num_masters];
   slave_idx_t  m_target [num_masters];
   data_t       m_wdata  [num_masters];
   logic        m_done   [num_masters];
   data_t       m_rdata  [num_masters];
   hresp_t      m_resp   [num_masters];

   logic        s_done   [num_slaves];
   data_t       s_rdata  [num_slaves];
   hresp_t      s_resp   [num_slaves];

   // per slave ownership
   logic        busy     [num_slaves];
   logic        issued   [num_slaves];
   master_idx_t owner    [num_slaves];

   logic        grant_valid [num_slaves];
   master_idx_t grant_idx   [num_slaves];

   genvar m;
   genvar s;

   generate
      for (m = 0; m < num_masters; m++) begin : g_master
         assign m_req[m]      = mlink[m].req;
         assign m_addr[m]     = mlink[m].addr;
         assign m_trans[m]    = mlink[m].trans;
         assign m_write[m]    = mlink[m].write;
         assign m_strobe[m]   = mlink[m].strobe;
         assign m_target[m]   = mlink[m].target;
         assign m_wdata[m]    = mlink[m].wdata;
         assign mlink[m].done  = m_done[m];
         assign mlink[m].rdata = m_rdata[m];
         assign mlink[m].resp  = m_resp[m];
      end

      for (s = 0; s < num_slaves; s++) begin : g_slave
         // first owned cycle is the slave address phase
         assign slink[s].start  = busy[s] && !issued[s];
         assign slink[s].addr   = m_addr[owner[s]];
         assign slink[s].trans  = m_trans[owner[s]];
         assign slink[s].write  = m_write[owner[s]];
         assign slink[s].strobe = m_strobe[owner[s]];
         assign slink[s].wdata  = m_wdata[owner[s]];
         assign s_done[s]       = slink[s].done;
         assign s_rdata[s]      = slink[s].rdata;
         assign s_resp[s]       = slink[s].resp;
      end
   endgenerate

   // fixed priority, scanning down so the lowest index wins
   always_comb begin
      for (int i = 0; i < num_slaves; i++) begin
         grant_valid[i] = 1'b0;
         grant_idx[i]   = '0;
         for (int j = num_masters - 1; j >= 0; j--) begin
            if (m_req[j] && m_target[j] == slave_idx_t'(i)) begin
               grant_valid[i] = 1'b1;
               grant_idx[i]   = master_idx_t'(j);
            end
         end
      end
   end

   always_ff @(posedge HCLOCK or negedge HRESETn) begin
      if (!HRESETn) begin
         for (int i = 0; i < num_slaves; i++) begin
            busy[i]   <= 1'b0;
            issued[i] <= 1'b0;
            owner[i]  <= '0;
         end
      end else begin
         for (int i = 0; i < num_slaves; i++) begin
            if (busy[i]) begin
               // slave frees up at the edge after done
               if (s_done[i]) begin
                  busy[i]   <= 1'b0;
                  issued[i] <= 1'b0;
               end else begin
                  issued[i] <= 1'b1;
               end
            end else if (grant_valid[i]) begin
               busy[i]  <= 1'b1;
               owner[i] <= grant_idx[i];
            end
         end
      end
   end

   // completion goes back to the owner only
   always_comb begin
      slave_idx_t t;
      logic       own;
      for (int j = 0; j < num_masters; j++) begin
         t         = m_target[j];
         own       = busy[t] && owner[t] == master_idx_t'(j);
         m_done[j]  = own && s_done[t];
         m_rdata[j] = own ? s_rdata[t] : '0;
         m_resp[j]  = own ? s_resp[t] : resp_okay;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds and runs the switch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module ahb_switch_tb -o sim_ahb_switch
status=$?
if [ $status -ne 0 ]; then
   echo "build failed"
   exit $status
fi

./obj_dir/sim_ahb_switch
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed"
   exit $status
fi
exit 0

/* tests/switch_tasks.svh */
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
   end
endtask

// expected lanes for each size and byte offset
function automatic strobe_t expected_lanes(input hsize_t sz, input int off);
   if (sz == size_byte) return strobe_t'(4'b0001 << off);
   if (sz == size_half) return (off == 2) ? 4'b1100 : 4'b0011;
   return 4'b1111;
endfunction

function automatic addr_t slave_base(input int s);
   return (s == 0) ? 32'h0000_0000 : 32'h4000_0000;
endfunction

// one AHB transfer started at a drive point with hready high
task automatic ahb_transfer(input int m, input addr_t a, input logic wr, input hsize_t sz,
                            input data_t wd, output data_t rd, output hresp_t rsp,
                            output int stall);
   int t;
   haddr[m]  = a;
   htrans[m] = trans_nonseq;
   hwrite[m] = wr;
   hsize[m]  = sz;
   @(posedge HCLOCK);
   #2;
   htrans[m] = trans_idle;
   hwdata[m] = wd;
   stall = 0;
   t = 0;
   @(negedge HCLOCK);
   while (!hready[m]) begin
      stall++;
      t++;
      if (t > timeout_cycles) fail_run($sformatf("master %0d transfer never completed", m));
      @(negedge HCLOCK);
   end
   rd  = hrdata[m];
   rsp = hresp[m];
   @(posedge HCLOCK);
   #2;
endtask

task automatic write_word(input int m, input addr_t a, input data_t wd);
   data_t  rd;
   hresp_t rsp;
   int     st;
   ahb_transfer(m, a, 1'b1, size_word, wd, rd, rsp, st);
   check_value("hresp", 32'(rsp), 32'(resp_okay));
endtask

task automatic read_check(input int m, input addr_t a, input data_t exp);
   data_t  rd;
   hresp_t rsp;
   int     st;
   ahb_transfer(m, a, 1'b0, size_word, '0, rd, rsp, st);
   check_value("hrdata", rd, exp);
   check_value("hresp", 32'(rsp), 32'(resp_okay));
endtask

task automatic write_read_all();
   for (int m = 0; m < num_masters; m++) begin
      for (int s = 0; s < num_slaves; s++) begin
         write_word(m, slave_base(s) + 8 * m, 32'hC0DE0000 | (m << 8) | s);
         read_check(m, slave_base(s) + 8 * m, 32'hC0DE0000 | (m << 8) | s);
      end
   end
endtask

task automatic byte_lane_test();
   data_t   rd;
   hresp_t  rsp;
   int      st;
   int      n;
   addr_t   a;
   strobe_t lanes;
   for (int s = 0; s < num_slaves; s++) begin
      for (int sz = 0; sz < 3; sz++) begin
         for (int off = 0; off < 4; off += (1 << sz)) begin
            n = cs_log[s].size();
            a = slave_base(s) + 32'h20 + off;
            lanes = expected_lanes(hsize_t'(sz), off);
            ahb_transfer(s, a, 1'b1, hsize_t'(sz), 32'h11223344, rd, rsp, st);
            check_value("cs count", cs_log[s].size(), n + 1);
            check_value("s_byte_enable", 32'(be_log[s][n]), 32'(lanes));
            check_value("s_address", cs_log[s][n], a);
            check_value("s_trans", 32'(trans_log[s][n]), 32'(trans_nonseq));
         end
      end
   end
endtask

// both masters hit one slave in the same cycle and master 0 goes first
task automatic same_slave_test();
   data_t  rd0;
   data_t  rd1;
   hresp_t r0;
   hresp_t r1;
   int     st0;
   int     st1;
   int     n;
   n = cs_log[1].size();
   fork
      ahb_transfer(0, 32'h4000_0010, 1'b1, size_word, 32'hAAAA0000, rd0, r0, st0);
      ahb_transfer(1, 32'h4000_0018, 1'b1, size_word, 32'hBBBB1111, rd1, r1, st1);
   join
   check_value("hresp master 0", 32'(r0), 32'(resp_okay));
   check_value("hresp master 1", 32'(r1), 32'(resp_okay));
   check_value("s_address first", cs_log[1][n], 32'h4000_0010);
   check_value("s_address second", cs_log[1][n + 1], 32'h4000_0018);
   read_check(1, 32'h4000_0010, 32'hAAAA0000);
   read_check(0, 32'h4000_0018, 32'hBBBB1111);
endtask

task automatic split_slave_test();
   data_t  rd0;
   data_t  rd1;
   hresp_t r0;
   hresp_t r1;
   int     st0;
   int     st1;
   int     n0;
   int     n1;
   n0 = cs_log[0].size();
   n1 = cs_log[1].size();
   fork
      ahb_transfer(0, 32'h0000_0030, 1'b1, size_word, 32'h0BAD5EED, rd0, r0, st0);
      ahb_transfer(1, 32'h4000_0034, 1'b1, size_word, 32'hFEEDF00D, rd1, r1, st1);
   join
   check_value("hresp master 0", 32'(r0), 32'(resp_okay));
   check_value("hresp master 1", 32'(r1), 32'(resp_okay));
   check_value("s_address slave 0", cs_log[0][n0], 32'h0000_0030);
   check_value("s_address slave 1", cs_log[1][n1], 32'h4000_0034);
   // no contention, so each stall is set by its own slave only
   check_value("hready low cycles master 0", st0, 2 + wait_log[0][$]);
   check_value("hready low cycles master 1", st1, 2 + wait_log[1][$]);
   fork
      ahb_transfer(0, 32'h0000_0030, 1'b0, size_word, '0, rd0, r0, st0);
      ahb_transfer(1, 32'h4000_0034, 1'b0, size_word, '0, rd1, r1, st1);
   join
   check_value("hrdata master 0", rd0, 32'h0BAD5EED);
   check_value("hrdata master 1", rd1, 32'hFEEDF00D);
endtask

// stall length is two cycles plus the slave's wait states
task automatic wait_state_test();
   data_t  rd;
   hresp_t rsp;
   int     st;
   zero_wait = 1'b1;
   ahb_transfer(0, 32'h0000_0004, 1'b0, size_word, '0, rd, rsp, st);
   check_value("hready low cycles", st, 2);
   zero_wait = 1'b0;
   for (int i = 0; i < 8; i++) begin
      ahb_transfer(i % 2, slave_base(i / 4) + 4 * i, 1'b0, size_word, '0, rd, rsp, st);
      check_value("hready low cycles", st, 2 + wait_log[i / 4][$]);
   end
endtask

task automatic unmapped_test();
   int n0;
   int n1;
   n0 = cs_log[0].size();
   n1 = cs_log[1].size();
   haddr[0]  = 32'h8000_0010;
   htrans[0] = trans_nonseq;
   hwrite[0] = 1'b0;
   @(posedge HCLOCK);
   #2;
   htrans[0] = trans_idle;
   @(negedge HCLOCK);
   check_value("hready", 32'(hready[0]), 32'd0);
   check_value("hresp", 32'(hresp[0]), 32'(resp_error));
   @(negedge HCLOCK);
   check_value("hready", 32'(hready[0]), 32'd1);
   check_value("hresp", 32'(hresp[0]), 32'(resp_error));
   repeat (4) @(posedge HCLOCK);
   #2;
   check_value("slave 0 cs count", cs_log[0].size(), n0);
   check_value("slave 1 cs count", cs_log[1].size(), n1);
endtask

/* tests/ahb_switch_tb.sv */
module ahb_switch_tb import ahb_switch_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int timeout_cycles = 64;

   logic    HCLOCK;
   logic    HRESETn;

   addr_t   haddr         [num_masters];
   htrans_t htrans        [num_masters];
   logic    hwrite        [num_masters];
   hsize_t  hsize         [num_masters];
   data_t   hwdata        [num_masters];
   logic    hready        [num_masters];
   data_t   hrdata        [num_masters];
   hresp_t  hresp         [num_masters];
   addr_t   s_address     [num_slaves];
   logic    s_chip_select [num_slaves];
   strobe_t s_byte_enable [num_slaves];
   logic    s_write       [num_slaves];
   htrans_t s_trans       [num_slaves];
   data_t   s_wdata       [num_slaves];
   data_t   s_rdata       [num_slaves];
   hresp_t  s_resp        [num_slaves];
   logic    s_ready       [num_slaves];

   // slave model state written only by the model process
   data_t   mem       [num_slaves][16];
   logic    active    [num_slaves];
   int      waits     [num_slaves];
   addr_t   cur_addr  [num_slaves];
   strobe_t cur_be    [num_slaves];
   logic    cur_wr    [num_slaves];
   addr_t   cs_log    [num_slaves][$];
   strobe_t be_log    [num_slaves][$];
   htrans_t trans_log [num_slaves][$];
   int      wait_log  [num_slaves][$];

   // set by the tests to force zero wait states
   logic        zero_wait;
   logic [15:0] lfsr_state;

   ahb_switch ahb_switch_inst (.*);

   initial begin
      HCLOCK = 1'b0;
      forever #20 HCLOCK = ~HCLOCK;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   // galois lfsr stepped once per bit taken
   function automatic int next_rand(input int nbits);
      int v;
      v = 0;
      for (int i = 0; i < nbits; i++) begin
         v = (v << 1) | int'(lfsr_state[0]);
         if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
         else lfsr_state = lfsr_state >> 1;
      end
      return v;
   endfunction

   // both chip-select slave models stepped once per cycle
   initial begin
      lfsr_state = 16'd63641;
      for (int s = 0; s < num_slaves; s++) begin
         s_ready[s] = 1'b0;
         s_rdata[s] = '0;
         s_resp[s]  = resp_okay;
         active[s]  = 1'b0;
         waits[s]   = 0;
         // fill pattern mixes slave and word index
         for (int i = 0; i < 16; i++) begin
            mem[s][i] = 32'hA5000000 ^ (s << 12) ^ (i * 32'h01010101);
         end
      end
      forever begin
         @(negedge HCLOCK);
         for (int s = 0; s < num_slaves; s++) begin
            if (active[s] && s_ready[s]) begin
               // end of data phase merges the enabled write lanes
               if (cur_wr[s]) begin
                  for (int k = 0; k < 4; k++) begin
                     if (cur_be[s][k]) begin
                        mem[s][cur_addr[s][5:2]][8*k +: 8] = s_wdata[s][8*k +: 8];
                     end
                  end
               end
               active[s] = 1'b0;
            end
            if (s_chip_select[s]) begin
               active[s]   = 1'b1;
               cur_addr[s] = s_address[s];
               cur_be[s]   = s_byte_enable[s];
               cur_wr[s]   = s_write[s];
               waits[s]    = zero_wait ? 0 : next_rand(2);
               cs_log[s].push_back(s_address[s]);
               be_log[s].push_back(s_byte_enable[s]);
               trans_log[s].push_back(s_trans[s]);
               wait_log[s].push_back(waits[s]);
            end
         end
         @(posedge HCLOCK);
         #2;
         for (int s = 0; s < num_slaves; s++) begin
            s_ready[s] = 1'b0;
            s_rdata[s] = '0;
            if (active[s] && waits[s] == 0) begin
               s_ready[s] = 1'b1;
               s_rdata[s] = cur_wr[s] ? '0 : mem[s][cur_addr[s][5:2]];
            end else if (active[s]) begin
               waits[s] = waits[s] - 1;
            end
         end
      end
   end

   `include "switch_tasks.svh"

   initial begin
      HRESETn   = 1'b0;
      zero_wait = 1'b0;
      for (int m = 0; m < num_masters; m++) begin
         haddr[m]  = '0;
         htrans[m] = trans_idle;
         hwrite[m] = 1'b0;
         hsize[m]  = size_word;
         hwdata[m] = '0;
      end
      repeat (16) @(posedge HCLOCK);
      #2;
      HRESETn = 1'b1;
      @(posedge HCLOCK);
      #2;
      // idle state out of reset
      for (int m = 0; m < num_masters; m++) begin
         check_value("hready", 32'(hready[m]), 32'd1);
         check_value("hresp", 32'(hresp[m]), 32'(resp_okay));
      end
      for (int s = 0; s < num_slaves; s++) begin
         check_value("s_chip_select", 32'(s_chip_select[s]), 32'd0);
      end
      write_read_all();
      byte_lane_test();
      same_slave_test();
      split_slave_test();
      wait_state_test();
      unmapped_test();
      $display("Everything OK");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+tests
design/ahb_switch_pkg.sv
design/master_link_if.sv
design/slave_link_if.sv
design/master_port.sv
design/switch_router.sv
design/slave_port.sv
design/ahb_switch.sv
tests/ahb_switch_tb.sv
